// ==== design/uart_seg_defs.svh ====
`ifndef UART_SEG_DEFS_SVH
`define UART_SEG_DEFS_SVH

// default clocks per bit, 25 MHz clock at 115200 baud.
`define UART_SEG_CLKS_PER_BIT 217

// 1 when the display pins are active low (common anode).
`define UART_SEG_ACTIVE_LOW 1

`endif

// ==== design/uart_seg_pkg.sv ====
package uart_seg_pkg;

  // receiver states.
  typedef enum logic [2:0] {
    RX_IDLE    = 3'd0,
    RX_START   = 3'd1,
    RX_DATA    = 3'd2,
    RX_STOP    = 3'd3,
    RX_CLEANUP = 3'd4
  } rx_state_e;

  // seven-segment pattern, bit 0 is segment a and bit 6 is segment g.
  // a set bit lights the segment.
  typedef logic [6:0] seg_t;

endpackage

// ==== design/hex_seg_decoder.sv ====
`timescale 1ns/1ps

module hex_seg_decoder (
  input  logic               i_clk,
  input  logic               i_reset,
  input  logic [3:0]         i_nibble,
  output uart_seg_pkg::seg_t o_seg
);

  // patterns are gfedcba, active high.
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      o_seg <= '0;
    end else begin
      case (i_nibble)
        4'h0:    o_seg <= 7'h3F;
        4'h1:    o_seg <= 7'h06;
        4'h2:    o_seg <= 7'h5B;
        4'h3:    o_seg <= 7'h4F;
        4'h4:    o_seg <= 7'h66;
        4'h5:    o_seg <= 7'h6D;
        4'h6:    o_seg <= 7'h7D;
        4'h7:    o_seg <= 7'h07;
        4'h8:    o_seg <= 7'h7F;
        4'h9:    o_seg <= 7'h6F;
        4'hA:    o_seg <= 7'h77;
        // lower case b and d keep them apart from 8 and 0.
        4'hB:    o_seg <= 7'h7C;
        4'hC:    o_seg <= 7'h39;
        4'hD:    o_seg <= 7'h5E;
        4'hE:    o_seg <= 7'h79;
        default: o_seg <= 7'h71;
      endcase
    end
  end

endmodule

// ==== design/uart_rx.sv ====
`timescale 1ns/1ps
`include "uart_seg_defs.svh"

module uart_rx #(
  parameter int CLKS_PER_BIT = `UART_SEG_CLKS_PER_BIT
) (
  input  logic       i_clk,
  input  logic       i_reset,
  input  logic       i_serial,
  output logic       o_rx_valid,
  output logic [7:0] o_rx_byte,
  output logic       o_rx_frame_err
);

  localparam int CNT_W = $clog2(CLKS_PER_BIT);
  localparam logic [CNT_W-1:0] HALF_BIT = CNT_W'(CLKS_PER_BIT / 2 - 1);
  localparam logic [CNT_W-1:0] FULL_BIT = CNT_W'(CLKS_PER_BIT - 1);

  logic                    serial_meta;
  logic                    serial_sync;
  uart_seg_pkg::rx_state_e state;
  logic [CNT_W-1:0]        clk_count;
  logic [2:0]              bit_idx;
  logic [7:0]              shift_reg;
  logic                    bit_done;

  // two-flop synchronizer, the line idles high.
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      serial_meta <= 1'b1;
      serial_sync <= 1'b1;
    end else begin
      serial_meta <= i_serial;
      serial_sync <= serial_meta;
    end
  end

  assign bit_done = (clk_count == FULL_BIT);

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      state          <= uart_seg_pkg::RX_IDLE;
      clk_count      <= '0;
      bit_idx        <= '0;
      o_rx_valid     <= 1'b0;
      o_rx_frame_err <= 1'b0;
    end else begin
      o_rx_valid     <= 1'b0;
      o_rx_frame_err <= 1'b0;
      case (state)
        uart_seg_pkg::RX_IDLE: begin
          clk_count <= '0;
          bit_idx   <= '0;
          if (!serial_sync) begin
            state <= uart_seg_pkg::RX_START;
          end
        end
        uart_seg_pkg::RX_START: begin
          // middle of the start bit, a high line here was a glitch.
          if (clk_count == HALF_BIT) begin
            clk_count <= '0;
            if (serial_sync) begin
              state <= uart_seg_pkg::RX_IDLE;
            end else begin
              state <= uart_seg_pkg::RX_DATA;
            end
          end else begin
            clk_count <= clk_count + 1'b1;
          end
        end
        uart_seg_pkg::RX_DATA: begin
          if (bit_done) begin
            clk_count <= '0;
            bit_idx   <= bit_idx + 3'd1;
            if (bit_idx == 3'd7) begin
              state <= uart_seg_pkg::RX_STOP;
            end
          end else begin
            clk_count <= clk_count + 1'b1;
          end
        end
        uart_seg_pkg::RX_STOP: begin
          if (bit_done) begin
            clk_count      <= '0;
            o_rx_valid     <= serial_sync;
            o_rx_frame_err <= !serial_sync;
            state          <= uart_seg_pkg::RX_CLEANUP;
          end else begin
            clk_count <= clk_count + 1'b1;
          end
        end
        uart_seg_pkg::RX_CLEANUP: begin
          state <= uart_seg_pkg::RX_IDLE;
        end
        default: begin
          state <= uart_seg_pkg::RX_IDLE;
        end
      endcase
    end
  end

  // data arrives lsb first, the byte only updates on a good stop bit.
  always_ff @(posedge i_clk) begin
    if (state == uart_seg_pkg::RX_DATA && bit_done) begin
      shift_reg <= {serial_sync, shift_reg[7:1]};
    end
    if (state == uart_seg_pkg::RX_STOP && bit_done && serial_sync) begin
      o_rx_byte <= shift_reg;
    end
  end

endmodule

// ==== design/seg_display_ctrl.sv ====
`timescale 1ns/1ps
`include "uart_seg_defs.svh"

module seg_display_ctrl (
  input  logic               i_clk,
  input  logic               i_reset,
  input  logic               i_rx_valid,
  input  logic [7:0]         i_rx_byte,
  input  logic               i_rx_frame_err,
  output uart_seg_pkg::seg_t o_seg_upper,
  output uart_seg_pkg::seg_t o_seg_lower
);

  localparam uart_seg_pkg::seg_t SEG_DASH = 7'h40;
  localparam uart_seg_pkg::seg_t POL_MASK = (`UART_SEG_ACTIVE_LOW != 0) ? 7'h7F : 7'h00;

  logic [7:0]         byte_q;
  logic               shown_q;
  logic               err_q;
  logic               shown_d;
  logic               err_d;
  uart_seg_pkg::seg_t dec_upper;
  uart_seg_pkg::seg_t dec_lower;
  uart_seg_pkg::seg_t pat_upper;
  uart_seg_pkg::seg_t pat_lower;

  always_ff @(posedge i_clk) begin
    if (i_rx_valid) begin
      byte_q <= i_rx_byte;
    end
  end

  // flags, then one stage to line up with the decoders.
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      shown_q <= 1'b0;
      err_q   <= 1'b0;
      shown_d <= 1'b0;
      err_d   <= 1'b0;
    end else begin
      if (i_rx_valid) begin
        shown_q <= 1'b1;
        err_q   <= 1'b0;
      end else if (i_rx_frame_err) begin
        err_q <= 1'b1;
      end
      shown_d <= shown_q;
      err_d   <= err_q;
    end
  end

  hex_seg_decoder dec_upper_i (
    .i_clk    (i_clk),
    .i_reset  (i_reset),
    .i_nibble (byte_q[7:4]),
    .o_seg    (dec_upper)
  );

  hex_seg_decoder dec_lower_i (
    .i_clk    (i_clk),
    .i_reset  (i_reset),
    .i_nibble (byte_q[3:0]),
    .o_seg    (dec_lower)
  );

  always_comb begin
    if (!shown_d) begin
      pat_upper = '0;
      pat_lower = '0;
    end else if (err_d) begin
      pat_upper = SEG_DASH;
      pat_lower = SEG_DASH;
    end else begin
      pat_upper = dec_upper;
      pat_lower = dec_lower;
    end
  end

  // blank display out of reset.
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      o_seg_upper <= POL_MASK;
      o_seg_lower <= POL_MASK;
    end else begin
      o_seg_upper <= pat_upper ^ POL_MASK;
      o_seg_lower <= pat_lower ^ POL_MASK;
    end
  end

endmodule

// ==== design/uart_seg_top.sv ====
`timescale 1ns/1ps
`include "uart_seg_defs.svh"

module uart_seg_top #(
  parameter int CLKS_PER_BIT = `UART_SEG_CLKS_PER_BIT
) (
  input  logic               i_clk,
  input  logic               i_reset,
  input  logic               i_uart_rx,
  output logic               o_rx_valid,
  output logic               o_rx_frame_err,
  // upper nibble.
  output uart_seg_pkg::seg_t o_seg_upper,
  // lower nibble.
  output uart_seg_pkg::seg_t o_seg_lower
);

  logic [7:0] rx_byte;

  uart_rx #(
    .CLKS_PER_BIT (CLKS_PER_BIT)
  ) uart_rx_i (
    .i_clk          (i_clk),
    .i_reset        (i_reset),
    .i_serial       (i_uart_rx),
    .o_rx_valid     (o_rx_valid),
    .o_rx_byte      (rx_byte),
    .o_rx_frame_err (o_rx_frame_err)
  );

  seg_display_ctrl seg_display_ctrl_i (
    .i_clk          (i_clk),
    .i_reset        (i_reset),
    .i_rx_valid     (o_rx_valid),
    .i_rx_byte      (rx_byte),
    .i_rx_frame_err (o_rx_frame_err),
    .o_seg_upper    (o_seg_upper),
    .o_seg_lower    (o_seg_lower)
  );

endmodule

// ==== tb/seg_checker.sv ====
`timescale 1ns/1ps

module seg_checker (
  input  logic       i_clk,
  input  logic       i_rx_valid,
  input  logic       i_rx_frame_err,
  input  logic [6:0] i_seg_upper,
  input  logic [6:0] i_seg_lower,
  input  logic       i_exp_push,
  input  logic       i_exp_err,
  input  logic [7:0] i_exp_byte,
  input  logic [6:0] i_exp_upper,
  input  logic [6:0] i_exp_lower,
  input  logic       i_now_check,
  input  logic [1:0] i_now_id,
  input  logic       i_flush,
  input  logic       i_report,
  output int         o_pass_count,
  output int         o_fail_count
);

  // entry is {err, byte, upper pins, lower pins}.
  logic [22:0] exp_q [$];
  logic [22:0] cur;
  logic [22:0] lost;
  int          wait_cnt = 0;
  int          pass_cnt = 0;
  int          fail_cnt = 0;

  assign o_pass_count = pass_cnt;
  assign o_fail_count = fail_cnt;

  function automatic string frame_name(input logic [22:0] e);
    if (e[22]) begin
      return $sformatf("frame_err_%02h", e[21:14]);
    end
    return $sformatf("byte_%02h", e[21:14]);
  endfunction

  function automatic string display_check_name(input logic [1:0] id);
    case (id)
      2'd0:    return "reset_blank";
      2'd1:    return "glitch_hold";
      default: return "display_check";
    endcase
  endfunction

  task automatic compare_pins(input string name, input logic [6:0] up, input logic [6:0] lo);
    if (i_seg_upper === up && i_seg_lower === lo) begin
      pass_cnt++;
      $display("ok   %s upper=%02h lower=%02h", name, up, lo);
    end else begin
      fail_cnt++;
      $display("Fail %s: expected upper=%02h lower=%02h, actual upper=%02h lower=%02h",
               name, up, lo, i_seg_upper, i_seg_lower);
    end
  endtask

  // sampled on the falling edge, the pins settle 3 cycles after a pulse.
  always @(negedge i_clk) begin
    if (i_exp_push) begin
      exp_q.push_back({i_exp_err, i_exp_byte, i_exp_upper, i_exp_lower});
    end
    if (wait_cnt > 0) begin
      wait_cnt = wait_cnt - 1;
      if (wait_cnt == 0) begin
        compare_pins(frame_name(cur), cur[13:7], cur[6:0]);
      end
    end
    if (i_rx_valid || i_rx_frame_err) begin
      if (exp_q.size() == 0) begin
        fail_cnt++;
        $display("unexpected receive pulse (valid=%b, frame_err=%b) with no frame pending",
                 i_rx_valid, i_rx_frame_err);
      end else begin
        cur = exp_q.pop_front();
        if (i_rx_frame_err != cur[22]) begin
          fail_cnt++;
          if (cur[22]) begin
            $display("%s: a good byte arrived where a framing error was expected",
                     frame_name(cur));
          end else begin
            $display("%s: a framing error arrived where a good byte was expected",
                     frame_name(cur));
          end
        end else begin
          wait_cnt = 3;
        end
      end
    end
    if (i_now_check) begin
      compare_pins(display_check_name(i_now_id), i_exp_upper, i_exp_lower);
    end
    if (i_flush) begin
      while (exp_q.size() > 0) begin
        lost = exp_q.pop_front();
        fail_cnt++;
        $display("%s: no receive pulse arrived for this frame", frame_name(lost));
      end
    end
    if (i_report) begin
      $display("checks: %0d passed, %0d failed", pass_cnt, fail_cnt);
    end
  end

endmodule

// ==== tb/tb_uart_seg.sv ====
`timescale 1ns/1ps
`include "uart_seg_defs.svh"

module tb_uart_seg;

  localparam int BIT_CLKS    = 16;
  localparam int RAND_BYTES  = 30;
  // 256 sweep, error, recovery, random burst, glitch and the frame after it.
  localparam int NUM_FRAMES  = 256 + 2 + RAND_BYTES + 2;
  localparam int CYCLE_LIMIT = NUM_FRAMES * 12 * BIT_CLKS + 2000;

  logic               clk;
  logic               reset;
  logic               uart_rx;
  logic               rx_valid;
  logic               rx_frame_err;
  uart_seg_pkg::seg_t seg_upper;
  uart_seg_pkg::seg_t seg_lower;

  logic       exp_push;
  logic       exp_err;
  logic [7:0] exp_byte;
  logic [6:0] exp_upper;
  logic [6:0] exp_lower;
  logic       now_check;
  logic [1:0] now_id;
  logic       flush;
  logic       report;
  int         pass_count;
  int         fail_count;
  int         expected_checks = 0;
  int         cycle_count = 0;

  // display state as the reference sees it.
  logic       shown_state;
  logic       err_state;
  logic [7:0] last_byte;
  logic [7:0] rand_bytes [RAND_BYTES];

  uart_seg_top #(
    .CLKS_PER_BIT (BIT_CLKS)
  ) uart_seg_top_i (
    .i_clk          (clk),
    .i_reset        (reset),
    .i_uart_rx      (uart_rx),
    .o_rx_valid     (rx_valid),
    .o_rx_frame_err (rx_frame_err),
    .o_seg_upper    (seg_upper),
    .o_seg_lower    (seg_lower)
  );

  seg_checker seg_checker_i (
    .i_clk          (clk),
    .i_rx_valid     (rx_valid),
    .i_rx_frame_err (rx_frame_err),
    .i_seg_upper    (seg_upper),
    .i_seg_lower    (seg_lower),
    .i_exp_push     (exp_push),
    .i_exp_err      (exp_err),
    .i_exp_byte     (exp_byte),
    .i_exp_upper    (exp_upper),
    .i_exp_lower    (exp_lower),
    .i_now_check    (now_check),
    .i_now_id       (now_id),
    .i_flush        (flush),
    .i_report       (report),
    .o_pass_count   (pass_count),
    .o_fail_count   (fail_count)
  );

  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("timeout: the run did not end within %0d cycles", CYCLE_LIMIT);
      $display("test failed");
      $finish;
    end
  end

  // standard hex digits with bit 0 as segment a.
  function automatic logic [6:0] hex_digit_pattern(input logic [3:0] n);
    case (n)
      4'h0:    return 7'b0111111;
      4'h1:    return 7'b0000110;
      4'h2:    return 7'b1011011;
      4'h3:    return 7'b1001111;
      4'h4:    return 7'b1100110;
      4'h5:    return 7'b1101101;
      4'h6:    return 7'b1111101;
      4'h7:    return 7'b0000111;
      4'h8:    return 7'b1111111;
      4'h9:    return 7'b1101111;
      4'hA:    return 7'b1110111;
      4'hB:    return 7'b1111100;
      4'hC:    return 7'b0111001;
      4'hD:    return 7'b1011110;
      4'hE:    return 7'b1111001;
      default: return 7'b1110001;
    endcase
  endfunction

  // expected pins as {upper, lower}.
  function automatic logic [13:0] expected_pins(input logic [7:0] b, input logic is_err,
                                                input logic is_shown);
    logic [6:0] up;
    logic [6:0] lo;
    if (!is_shown) begin
      up = 7'h00;
      lo = 7'h00;
    end else if (is_err) begin
      up = 7'b1000000;
      lo = 7'b1000000;
    end else begin
      up = hex_digit_pattern(b[7:4]);
      lo = hex_digit_pattern(b[3:0]);
    end
    // common anode pins light on a low level.
    if (`UART_SEG_ACTIVE_LOW != 0) begin
      up = ~up;
      lo = ~lo;
    end
    return {up, lo};
  endfunction

  task automatic expect_frame(input logic [7:0] b, input logic bad_stop);
    logic [13:0] pins;
    if (bad_stop) begin
      err_state = 1'b1;
    end else begin
      shown_state = 1'b1;
      err_state   = 1'b0;
      last_byte   = b;
    end
    pins = expected_pins(last_byte, err_state, shown_state);
    @(posedge clk);
    exp_push  <= 1'b1;
    exp_err   <= bad_stop;
    exp_byte  <= b;
    exp_upper <= pins[13:7];
    exp_lower <= pins[6:0];
    @(posedge clk);
    exp_push <= 1'b0;
    expected_checks++;
  endtask

  task automatic check_display_now(input logic [1:0] id);
    logic [13:0] pins;
    pins = expected_pins(last_byte, err_state, shown_state);
    @(posedge clk);
    now_check <= 1'b1;
    now_id    <= id;
    exp_upper <= pins[13:7];
    exp_lower <= pins[6:0];
    @(posedge clk);
    now_check <= 1'b0;
    expected_checks++;
  endtask

  task automatic drive_line(input logic level, input int clks);
    @(posedge clk);
    uart_rx <= level;
    repeat (clks - 1) @(posedge clk);
  endtask

  task automatic send_frame(input logic [7:0] b, input logic bad_stop);
    int i;
    drive_line(1'b0, BIT_CLKS);
    for (i = 0; i < 8; i++) begin
      drive_line(b[i], BIT_CLKS);
    end
    drive_line(!bad_stop, BIT_CLKS);
  endtask

  task automatic idle_line(input int bits);
    drive_line(1'b1, bits * BIT_CLKS);
  endtask

  // wait for the pending checks, then flush what is still queued.
  task automatic wait_for_checks();
    int waited;
    waited = 0;
    while ((pass_count + fail_count) < expected_checks && waited < 4 * BIT_CLKS) begin
      @(posedge clk);
      waited++;
    end
    if ((pass_count + fail_count) < expected_checks) begin
      @(posedge clk);
      flush <= 1'b1;
      @(posedge clk);
      flush <= 1'b0;
    end
  endtask

  initial begin
    int idx;
    logic [31:0] rnd;
    clk         = 1'b0;
    reset       = 1'b1;
    uart_rx     = 1'b1;
    exp_push    = 1'b0;
    exp_err     = 1'b0;
    exp_byte    = 8'h00;
    exp_upper   = 7'h00;
    exp_lower   = 7'h00;
    now_check   = 1'b0;
    now_id      = 2'd0;
    flush       = 1'b0;
    report      = 1'b0;
    shown_state = 1'b0;
    err_state   = 1'b0;
    last_byte   = 8'h00;
    void'($urandom(32'h5974_a807));
    repeat (16) @(posedge clk);
    reset <= 1'b0;

    idle_line(4);
    check_display_now(2'd0);
    wait_for_checks();

    for (idx = 0; idx < 256; idx++) begin
      expect_frame(idx[7:0], 1'b0);
      send_frame(idx[7:0], 1'b0);
      idle_line(2);
      wait_for_checks();
    end

    expect_frame(8'hA5, 1'b1);
    send_frame(8'hA5, 1'b1);
    idle_line(2);
    wait_for_checks();
    expect_frame(8'h3C, 1'b0);
    send_frame(8'h3C, 1'b0);
    idle_line(2);
    wait_for_checks();

    // whole burst is queued first so the frames run back to back.
    for (idx = 0; idx < RAND_BYTES; idx++) begin
      rnd = $urandom();
      rand_bytes[idx] = rnd[7:0];
      expect_frame(rand_bytes[idx], 1'b0);
    end
    for (idx = 0; idx < RAND_BYTES; idx++) begin
      send_frame(rand_bytes[idx], 1'b0);
    end
    idle_line(2);
    wait_for_checks();

    drive_line(1'b0, BIT_CLKS / 4);
    idle_line(3);
    check_display_now(2'd1);
    wait_for_checks();
    expect_frame(8'hE7, 1'b0);
    send_frame(8'hE7, 1'b0);
    idle_line(2);
    wait_for_checks();

    @(posedge clk);
    report <= 1'b1;
    @(posedge clk);
    report <= 1'b0;
    @(posedge clk);
    if (fail_count == 0 && pass_count == expected_checks) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// ==== src.f ====
+incdir+design
design/uart_seg_pkg.sv
design/hex_seg_decoder.sv
design/uart_rx.sv
design/seg_display_ctrl.sv
design/uart_seg_top.sv
tb/seg_checker.sv
tb/tb_uart_seg.sv

// ==== Makefile ====
# Verilator build and run for the UART to seven-segment project.

VERILATOR  ?= verilator
TOP        ?= tb_uart_seg
FILELIST   ?= src.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
FAIL_MSG   ?= test failed
VFLAGS     ?= --binary --timing -j 0 -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --Mdir $(BUILD_DIR) --top-module $(TOP) -f $(FILELIST)

run: build
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "simulation FAILED, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
